/* files.f */
+incdir+.
alert_wrap_pkg.sv
alert_reg_file.sv
alert_irq_ctrl.sv
alert_class_cfg.sv
alert_crashdump.sv
alert_handler_wrap.sv
tb_alert_handler_wrap.sv

/* tb_alert_handler_wrap.sv */
// testbench for the alert handler register wrapper
// table-driven register accesses, hardware stimulus and output checks
`timescale 1ns/100ps
`include "alert_wrap_defines.svh"

module tb_alert_handler_wrap;

  typedef enum int {op_wr, op_rd, op_hw, op_chk} op_e;
  // where the expected value of a row comes from
  typedef enum int {src_table, src_live, src_snap} src_e;

  localparam int max_rows = 80;

  // hardware input selectors for op_hw rows
  localparam int hw_ctrig = 0;
  localparam int hw_etrig = 1;
  localparam int hw_atrig = 2;
  localparam int hw_accum = 3;
  localparam int hw_state = 4;
  localparam int hw_latch = 5;

  // output selectors for op_chk rows
  localparam int out_irq      = 0;
  localparam int out_cls_en   = 1;
  localparam int out_cls_clr  = 2;
  localparam int out_esc_en   = 3;
  localparam int out_esc_map  = 4;
  localparam int out_alert_en = 5;
  localparam int out_cd_cause = 6;
  localparam int out_cd_accum = 7;
  localparam int out_cd_state = 8;

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        wr_en_i;
  logic                                        rd_en_i;
  logic                                        latch_crashdump_i;
  alert_wrap_pkg::reg_addr_t                   addr_i;
  alert_wrap_pkg::reg_data_t                   wdata_i;
  alert_wrap_pkg::reg_data_t                   rdata_o;
  alert_wrap_pkg::class_vec_t                  class_trig_i;
  alert_wrap_pkg::class_vec_t                  esc_trig_i;
  alert_wrap_pkg::class_vec_t                  irq_o;
  alert_wrap_pkg::class_vec_t                  class_en_o;
  alert_wrap_pkg::class_vec_t                  class_clr_o;
  alert_wrap_pkg::alert_vec_t                  alert_trig_i;
  alert_wrap_pkg::alert_vec_t                  alert_en_o;
  alert_wrap_pkg::alert_vec_t                  crashdump_cause_o;
  alert_wrap_pkg::esc_en_t                     class_esc_en_o;
  alert_wrap_pkg::esc_map_t                    class_esc_map_o;
  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] accum_cnt_i;
  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] crashdump_accum_o;
  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] accum_snap;
  alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] esc_state_i;
  alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] crashdump_state_o;

  string       row_name [max_rows];
  op_e         row_op   [max_rows];
  int          row_sel  [max_rows];
  logic [31:0] row_data [max_rows];
  logic [63:0] row_exp  [max_rows];
  src_e        row_src  [max_rows];
  int          n_rows = 0;
  int          cycles = 0;
  bit          table_ready = 1'b0;

  alert_handler_wrap UUT (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .wr_en_i           ( wr_en_i           ),
    .rd_en_i           ( rd_en_i           ),
    .addr_i            ( addr_i            ),
    .wdata_i           ( wdata_i           ),
    .rdata_o           ( rdata_o           ),
    .class_trig_i      ( class_trig_i      ),
    .esc_trig_i        ( esc_trig_i        ),
    .alert_trig_i      ( alert_trig_i      ),
    .accum_cnt_i       ( accum_cnt_i       ),
    .esc_state_i       ( esc_state_i       ),
    .latch_crashdump_i ( latch_crashdump_i ),
    .irq_o             ( irq_o             ),
    .class_en_o        ( class_en_o        ),
    .class_clr_o       ( class_clr_o       ),
    .alert_en_o        ( alert_en_o        ),
    .class_esc_en_o    ( class_esc_en_o    ),
    .class_esc_map_o   ( class_esc_map_o   ),
    .crashdump_cause_o ( crashdump_cause_o ),
    .crashdump_accum_o ( crashdump_accum_o ),
    .crashdump_state_o ( crashdump_state_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic add_row(input string name, input op_e op, input int sel,
                         input logic [31:0] data, input logic [63:0] exp_v, input src_e src);
    row_name[n_rows] = name;
    row_op[n_rows]   = op;
    row_sel[n_rows]  = sel;
    row_data[n_rows] = data;
    row_exp[n_rows]  = exp_v;
    row_src[n_rows]  = src;
    n_rows++;
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act);
    assert (act === exp_v) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act);
      $display("TB FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic drive_hw(input int sel, input logic [31:0] data);
    case (sel)
      hw_ctrig: class_trig_i = data[`N_CLASSES-1:0];
      hw_etrig: esc_trig_i = data[`N_CLASSES-1:0];
      hw_atrig: alert_trig_i = data[`N_ALERTS-1:0];
      hw_accum: begin
        for (int c = 0; c < `N_CLASSES; c++) begin
          accum_cnt_i[c] = alert_wrap_pkg::accum_cnt_t'($urandom());
        end
      end
      hw_state: begin
        for (int c = 0; c < `N_CLASSES; c++) begin
          esc_state_i[c] = alert_wrap_pkg::esc_state_e'(data[3*c +: 3]);
        end
      end
      default: begin
        latch_crashdump_i = data[0];
        // counts stay put while the request is up, so the edge sees these
        if (data[0]) begin
          accum_snap = accum_cnt_i;
        end
      end
    endcase
  endtask

  function automatic logic [63:0] sample_output(input int sel);
    logic [63:0] v;
    v = '0;
    case (sel)
      out_irq:      v[`N_CLASSES-1:0] = irq_o;
      out_cls_en:   v[`N_CLASSES-1:0] = class_en_o;
      out_cls_clr:  v[`N_CLASSES-1:0] = class_clr_o;
      out_esc_en:   v[15:0] = class_esc_en_o;
      out_esc_map:  v[31:0] = class_esc_map_o;
      out_alert_en: v[`N_ALERTS-1:0] = alert_en_o;
      out_cd_cause: v[`N_ALERTS-1:0] = crashdump_cause_o;
      out_cd_accum: v = crashdump_accum_o;
      default:      v[11:0] = crashdump_state_o;
    endcase
    return v;
  endfunction

  // status reads add the live count of the addressed class to the table value
  function automatic logic [63:0] expected_value(input int i);
    logic [63:0] e;
    e = row_exp[i];
    if (row_src[i] == src_snap) begin
      e = accum_snap;
    end else if (row_src[i] == src_live && row_op[i] == op_rd) begin
      e = e | accum_cnt_i[row_sel[i] - `ADDR_CLASS_STATUS];
    end else if (row_src[i] == src_live) begin
      e = accum_cnt_i;
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    // interrupts
    add_row("irq_en_wr",      op_wr,  `ADDR_INTR_ENABLE,     1, 0, src_table);
    add_row("trig_c0",        op_hw,  hw_ctrig,              1, 0, src_table);
    add_row("irq_c0_rise",    op_chk, out_irq,               0, 1, src_table);
    add_row("trig_c1",        op_hw,  hw_ctrig,              2, 0, src_table);
    add_row("trig_off",       op_hw,  hw_ctrig,              0, 0, src_table);
    add_row("state_c0_c1",    op_rd,  `ADDR_INTR_STATE,      0, 3, src_table);
    add_row("irq_c1_masked",  op_chk, out_irq,               0, 1, src_table);
    add_row("state_w1c",      op_wr,  `ADDR_INTR_STATE,      3, 0, src_table);
    add_row("irq_cleared",    op_chk, out_irq,               0, 0, src_table);
    add_row("irq_en_c2",      op_wr,  `ADDR_INTR_ENABLE,     4, 0, src_table);
    add_row("test_c2",        op_wr,  `ADDR_INTR_TEST,       4, 0, src_table);
    add_row("irq_c2_test",    op_chk, out_irq,               0, 4, src_table);
    add_row("state_c2_test",  op_rd,  `ADDR_INTR_STATE,      0, 4, src_table);
    // sticky alert causes
    add_row("cause_trig",     op_hw,  hw_atrig,          8'h05, 0, src_table);
    add_row("cause_trig_off", op_hw,  hw_atrig,              0, 0, src_table);
    add_row("cause_sticky",   op_rd,  `ADDR_ALERT_CAUSE,     0, 5, src_table);
    add_row("cause_w1c",      op_wr,  `ADDR_ALERT_CAUSE,     1, 0, src_table);
    add_row("cause_after",    op_rd,  `ADDR_ALERT_CAUSE,     0, 4, src_table);
    add_row("alert_en_wr",    op_wr,  `ADDR_ALERT_EN,    8'ha5, 0, src_table);
    add_row("alert_en_out",   op_chk, out_alert_en,          0, 8'ha5, src_table);
    // class control decode
    add_row("ctrl_c0_no_e",   op_wr,  `ADDR_CLASS_CTRL,      1, 0, src_table);
    add_row("cls_en_no_e",    op_chk, out_cls_en,            0, 0, src_table);
    add_row("ctrl_c0_wr",     op_wr,  `ADDR_CLASS_CTRL, 32'h3915, 0, src_table);
    add_row("cls_en_c0",      op_chk, out_cls_en,            0, 1, src_table);
    add_row("ctrl_c1_wr",     op_wr,  `ADDR_CLASS_CTRL + 1, 32'hffff_c6ff, 0, src_table);
    add_row("ctrl_c1_rd",     op_rd,  `ADDR_CLASS_CTRL + 1,  0, 32'h06ff, src_table);
    add_row("cls_en_c1",      op_chk, out_cls_en,            0, 3, src_table);
    add_row("esc_en_c1",      op_chk, out_esc_en,            0, 16'h00f5, src_table);
    add_row("esc_map_c1",     op_chk, out_esc_map,           0, 32'h1be4, src_table);
    add_row("ctrl_c2_wr",     op_wr,  `ADDR_CLASS_CTRL + 2, 32'h21, 0, src_table);
    // clear pulse and autolock
    add_row("clr_c0_wr",      op_wr,  `ADDR_CLASS_CLR,       1, 0, src_table);
    add_row("clr_c0_pulse",   op_chk, out_cls_clr,           0, 1, src_table);
    add_row("clr_c0_done",    op_chk, out_cls_clr,           0, 0, src_table);
    add_row("esc_c1",         op_hw,  hw_etrig,              2, 0, src_table);
    add_row("esc_c1_off",     op_hw,  hw_etrig,              0, 0, src_table);
    add_row("regwen_c1_lock", op_rd,  `ADDR_CLR_REGWEN + 1,  0, 0, src_table);
    add_row("clr_c1_wr",      op_wr,  `ADDR_CLASS_CLR + 1,   1, 0, src_table);
    add_row("clr_c1_blocked", op_chk, out_cls_clr,           0, 0, src_table);
    add_row("esc_c2",         op_hw,  hw_etrig,              4, 0, src_table);
    add_row("esc_c2_off",     op_hw,  hw_etrig,              0, 0, src_table);
    add_row("regwen_c2_open", op_rd,  `ADDR_CLR_REGWEN + 2,  0, 1, src_table);
    // crashdump with states Phase1, Terminal, Idle and Phase3
    add_row("cnt_rand",       op_hw,  hw_accum,              0, 0, src_table);
    add_row("state_set",      op_hw,  hw_state,     32'h0c14, 0, src_table);
    add_row("cd_live_accum",  op_chk, out_cd_accum,          0, 0, src_live);
    add_row("cd_live_state",  op_chk, out_cd_state,          0, 64'h0c14, src_table);
    add_row("status_c0",      op_rd,  `ADDR_CLASS_STATUS,    0, 32'h0004_0000, src_live);
    add_row("latch_req",      op_hw,  hw_latch,              1, 0, src_table);
    add_row("latch_off",      op_hw,  hw_latch,              0, 0, src_table);
    add_row("cnt_rand2",      op_hw,  hw_accum,              0, 0, src_table);
    add_row("cause_new",      op_hw,  hw_atrig,          8'h80, 0, src_table);
    add_row("cause_new_off",  op_hw,  hw_atrig,              0, 0, src_table);
    add_row("state_err",      op_hw,  hw_state,     32'h0fff, 0, src_table);
    add_row("cd_held_accum",  op_chk, out_cd_accum,          0, 0, src_snap);
    add_row("cd_held_state",  op_chk, out_cd_state,          0, 64'h0c14, src_table);
    add_row("cd_held_cause",  op_chk, out_cd_cause,          0, 4, src_table);
    add_row("clr_release",    op_wr,  `ADDR_CLASS_CLR,       1, 0, src_table);
    add_row("cd_still_held",  op_chk, out_cd_cause,          0, 4, src_table);
    add_row("cd_rel_cause",   op_chk, out_cd_cause,          0, 8'h84, src_table);
    add_row("cd_rel_accum",   op_chk, out_cd_accum,          0, 0, src_live);
  endtask

  ////////////////////////////////////////
  // apply loop
  ////////////////////////////////////////

  initial begin
    int unsigned seed_val;
    seed_val          = $urandom(32'hfa2a);
    rst_ni            = 1'b0;
    wr_en_i           = 1'b0;
    rd_en_i           = 1'b0;
    addr_i            = '0;
    wdata_i           = '0;
    class_trig_i      = '0;
    esc_trig_i        = '0;
    alert_trig_i      = '0;
    accum_cnt_i       = '0;
    accum_snap        = '0;
    latch_crashdump_i = 1'b0;
    for (int c = 0; c < `N_CLASSES; c++) begin
      esc_state_i[c] = alert_wrap_pkg::Idle;
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk_i);
      #2;
      // strobes last one edge
      wr_en_i = 1'b0;
      rd_en_i = 1'b0;
      case (row_op[i])
        op_wr: begin
          wr_en_i = 1'b1;
          addr_i  = row_sel[i];
          wdata_i = row_data[i];
        end
        op_rd: begin
          rd_en_i = 1'b1;
          addr_i  = row_sel[i];
          @(posedge clk_i);
          #2;
          rd_en_i = 1'b0;
          check_value(row_name[i], expected_value(i), rdata_o);
        end
        op_hw: drive_hw(row_sel[i], row_data[i]);
        default: check_value(row_name[i], expected_value(i), sample_output(row_sel[i]));
      endcase
    end
    @(posedge clk_i);
    $display("TB PASSED");
    $finish;
  end

  // each row needs at most two cycles
  initial begin
    wait (table_ready);
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > n_rows * 4) begin
        $display("timeout after %0d cycles, the table was not finished", cycles);
        $display("TB FAILED");
        $fatal(1, "timeout");
      end
    end
  end

endmodule

/* alert_handler_wrap.sv */
// alert handler register wrapper, top level
// ties the register file, interrupts, class decode and crashdump to a
// plain strobe register port and the hardware-side signals
`timescale 1ns/100ps
`include "alert_wrap_defines.svh"

module alert_handler_wrap (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // register port
  input  logic                                       wr_en_i,
  input  logic                                       rd_en_i,
  input  alert_wrap_pkg::reg_addr_t                  addr_i,
  input  alert_wrap_pkg::reg_data_t                  wdata_i,
  output alert_wrap_pkg::reg_data_t                  rdata_o,
  // hardware side
  input  alert_wrap_pkg::class_vec_t                 class_trig_i,
  input  alert_wrap_pkg::class_vec_t                 esc_trig_i,
  input  alert_wrap_pkg::alert_vec_t                 alert_trig_i,
  input  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] accum_cnt_i,
  input  alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] esc_state_i,
  input  logic                                       latch_crashdump_i,
  output alert_wrap_pkg::class_vec_t                 irq_o,
  output alert_wrap_pkg::class_vec_t                 class_en_o,
  output alert_wrap_pkg::class_vec_t                 class_clr_o,
  output alert_wrap_pkg::alert_vec_t                 alert_en_o,
  output alert_wrap_pkg::esc_en_t                    class_esc_en_o,
  output alert_wrap_pkg::esc_map_t                   class_esc_map_o,
  // crashdump
  output alert_wrap_pkg::alert_vec_t                 crashdump_cause_o,
  output alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] crashdump_accum_o,
  output alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] crashdump_state_o
);

  alert_wrap_pkg::class_vec_t                 intr_enable;
  alert_wrap_pkg::class_vec_t                 intr_test;
  alert_wrap_pkg::class_vec_t                 intr_clr;
  alert_wrap_pkg::class_vec_t                 intr_state;
  alert_wrap_pkg::alert_vec_t                 alert_cause;
  alert_wrap_pkg::reg_data_t [`N_CLASSES-1:0] class_ctrl;
  alert_wrap_pkg::class_vec_t                 class_clr;
  alert_wrap_pkg::class_vec_t                 autolock_clr;

  alert_reg_file u_reg_file (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .wr_en_i        ( wr_en_i        ),
    .rd_en_i        ( rd_en_i        ),
    .addr_i         ( addr_i         ),
    .wdata_i        ( wdata_i        ),
    .rdata_o        ( rdata_o        ),
    .alert_trig_i   ( alert_trig_i   ),
    .intr_state_i   ( intr_state     ),
    .autolock_clr_i ( autolock_clr   ),
    .accum_cnt_i    ( accum_cnt_i    ),
    .esc_state_i    ( esc_state_i    ),
    .intr_enable_o  ( intr_enable    ),
    .intr_test_o    ( intr_test      ),
    .intr_clr_o     ( intr_clr       ),
    .alert_cause_o  ( alert_cause    ),
    .alert_en_o     ( alert_en_o     ),
    .class_ctrl_o   ( class_ctrl     ),
    .class_clr_o    ( class_clr      )
  );

  alert_irq_ctrl u_irq_ctrl (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .class_trig_i  ( class_trig_i ),
    .intr_test_i   ( intr_test    ),
    .intr_clr_i    ( intr_clr     ),
    .intr_enable_i ( intr_enable  ),
    .intr_state_o  ( intr_state   ),
    .irq_o         ( irq_o        )
  );

  alert_class_cfg u_class_cfg (
    .class_ctrl_i    ( class_ctrl      ),
    .esc_trig_i      ( esc_trig_i      ),
    .class_en_o      ( class_en_o      ),
    .class_esc_en_o  ( class_esc_en_o  ),
    .class_esc_map_o ( class_esc_map_o ),
    .autolock_clr_o  ( autolock_clr    )
  );

  alert_crashdump u_crashdump (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .latch_crashdump_i ( latch_crashdump_i ),
    .class_clr_i       ( class_clr         ),
    .alert_cause_i     ( alert_cause       ),
    .accum_cnt_i       ( accum_cnt_i       ),
    .esc_state_i       ( esc_state_i       ),
    .crashdump_cause_o ( crashdump_cause_o ),
    .crashdump_accum_o ( crashdump_accum_o ),
    .crashdump_state_o ( crashdump_state_o )
  );

  assign class_clr_o = class_clr;

endmodule

/* alert_crashdump.sv */
// alert handler crashdump
// passes live cause, count and state through until the first latch
// request, then holds that snapshot until any class clear
`timescale 1ns/100ps
`include "alert_wrap_defines.svh"

module alert_crashdump (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       latch_crashdump_i,
  input  alert_wrap_pkg::class_vec_t                 class_clr_i,
  input  alert_wrap_pkg::alert_vec_t                 alert_cause_i,
  input  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] accum_cnt_i,
  input  alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] esc_state_i,
  output alert_wrap_pkg::alert_vec_t                 crashdump_cause_o,
  output alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] crashdump_accum_o,
  output alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] crashdump_state_o
);

  logic                                      latched_q;
  alert_wrap_pkg::alert_vec_t                cause_q;
  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] accum_q;
  alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] state_q;

  ////////////////////////////////////////
  // snapshot
  ////////////////////////////////////////

  // only the first request is captured, later ones are ignored until a
  // clear rearms the latch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latched_q <= 1'b0;
      cause_q   <= '0;
      accum_q   <= '0;
      for (int c = 0; c < `N_CLASSES; c++) begin
        state_q[c] <= alert_wrap_pkg::Idle;
      end
    end else if (|class_clr_i) begin
      latched_q <= 1'b0;
      cause_q   <= '0;
      accum_q   <= '0;
      for (int c = 0; c < `N_CLASSES; c++) begin
        state_q[c] <= alert_wrap_pkg::Idle;
      end
    end else if (latch_crashdump_i && !latched_q) begin
      latched_q <= 1'b1;
      cause_q   <= alert_cause_i;
      accum_q   <= accum_cnt_i;
      state_q   <= esc_state_i;
    end
  end

  // live view until latched
  assign crashdump_cause_o = latched_q ? cause_q : alert_cause_i;
  assign crashdump_accum_o = latched_q ? accum_q : accum_cnt_i;
  assign crashdump_state_o = latched_q ? state_q : esc_state_i;

endmodule

/* alert_class_cfg.sv */
// alert handler class control decode
// splits each class control word into class enable, escalation signal
// enables, the phase-to-signal map and the autolock request
`timescale 1ns/100ps
`include "alert_wrap_defines.svh"

module alert_class_cfg (
  input  alert_wrap_pkg::reg_data_t [`N_CLASSES-1:0] class_ctrl_i,
  input  alert_wrap_pkg::class_vec_t                 esc_trig_i,
  output alert_wrap_pkg::class_vec_t                 class_en_o,
  output alert_wrap_pkg::esc_en_t                    class_esc_en_o,
  output alert_wrap_pkg::esc_map_t                   class_esc_map_o,
  output alert_wrap_pkg::class_vec_t                 autolock_clr_o
);

  // map field width per class
  localparam int map_w = 2 * `N_ESC_SEV;

  for (genvar c = 0; c < `N_CLASSES; c++) begin : gen_class
    logic                 en;
    logic                 lock;
    logic [`N_ESC_SEV-1:0] en_e;
    logic [map_w-1:0]     map;

    assign en   = class_ctrl_i[c][`CTRL_EN_BIT];
    assign lock = class_ctrl_i[c][`CTRL_LOCK_BIT];
    assign en_e = class_ctrl_i[c][`CTRL_EN_E_LSB +: `N_ESC_SEV];
    assign map  = class_ctrl_i[c][`CTRL_MAP_LSB +: map_w];

    // a class without any escalation signal enabled counts as disabled
    assign class_en_o[c] = en & (|en_e);

    assign class_esc_en_o[c*`N_ESC_SEV +: `N_ESC_SEV] = en_e;
    assign class_esc_map_o[c*map_w +: map_w]          = map;

    // locked and enabled class entering escalation drops its clear enable
    assign autolock_clr_o[c] = esc_trig_i[c] & lock & class_en_o[c];
  end

endmodule

/* alert_irq_ctrl.sv */
// alert handler class interrupts
// one state bit per class, set by hardware or test, cleared by software
`timescale 1ns/100ps
`include "alert_wrap_defines.svh"

module alert_irq_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  alert_wrap_pkg::class_vec_t class_trig_i,
  input  alert_wrap_pkg::class_vec_t intr_test_i,
  input  alert_wrap_pkg::class_vec_t intr_clr_i,
  input  alert_wrap_pkg::class_vec_t intr_enable_i,
  output alert_wrap_pkg::class_vec_t intr_state_o,
  output alert_wrap_pkg::class_vec_t irq_o
);

  alert_wrap_pkg::class_vec_t state_d;
  alert_wrap_pkg::class_vec_t state_q;
  alert_wrap_pkg::class_vec_t irq_q;

  // a new event wins over a write-one-to-clear in the same cycle
  assign state_d = (state_q & ~intr_clr_i) | class_trig_i | intr_test_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  // irq taken from the next state so it rises together with the state bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= '0;
    end else begin
      irq_q <= state_d & intr_enable_i;
    end
  end

  assign intr_state_o = state_q;
  assign irq_o        = irq_q;

endmodule

/* alert_reg_file.sv */
// alert handler register file
// software-visible storage, write decode, registered read mux and the
// class clear pulse gated by the per-class clear enable
`timescale 1ns/100ps
`include "alert_wrap_defines.svh"

module alert_reg_file (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // register port
  input  logic                                      wr_en_i,
  input  logic                                      rd_en_i,
  input  alert_wrap_pkg::reg_addr_t                 addr_i,
  input  alert_wrap_pkg::reg_data_t                 wdata_i,
  output alert_wrap_pkg::reg_data_t                 rdata_o,
  // hardware side
  input  alert_wrap_pkg::alert_vec_t                alert_trig_i,
  input  alert_wrap_pkg::class_vec_t                intr_state_i,
  input  alert_wrap_pkg::class_vec_t                autolock_clr_i,
  input  alert_wrap_pkg::accum_cnt_t [`N_CLASSES-1:0] accum_cnt_i,
  input  alert_wrap_pkg::esc_state_e [`N_CLASSES-1:0] esc_state_i,
  // register outputs
  output alert_wrap_pkg::class_vec_t                intr_enable_o,
  output alert_wrap_pkg::class_vec_t                intr_test_o,
  output alert_wrap_pkg::class_vec_t                intr_clr_o,
  output alert_wrap_pkg::alert_vec_t                alert_cause_o,
  output alert_wrap_pkg::alert_vec_t                alert_en_o,
  output alert_wrap_pkg::reg_data_t [`N_CLASSES-1:0] class_ctrl_o,
  output alert_wrap_pkg::class_vec_t                class_clr_o
);

  // implemented bits of a control word
  localparam int ctrl_w = `CTRL_MAP_LSB + 2 * `N_ESC_SEV;
  // low address bits select the class within a four-word group
  localparam int cls_w  = $clog2(`N_CLASSES);

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  logic [cls_w-1:0]            cls_idx;
  alert_wrap_pkg::reg_addr_t   addr_base;
  alert_wrap_pkg::class_vec_t  cls_sel;
  logic                        wr_intr_state;
  logic                        wr_intr_enable;
  logic                        wr_intr_test;
  logic                        wr_alert_cause;
  logic                        wr_alert_en;
  alert_wrap_pkg::class_vec_t  wr_ctrl;
  alert_wrap_pkg::class_vec_t  wr_regwen;
  alert_wrap_pkg::class_vec_t  wr_clr;

  assign cls_idx   = addr_i[cls_w-1:0];
  assign addr_base = {addr_i[`ADDR_W-1:cls_w], {cls_w{1'b0}}};
  assign cls_sel   = alert_wrap_pkg::class_vec_t'(1) << cls_idx;

  assign wr_intr_state  = wr_en_i && (addr_i == `ADDR_INTR_STATE);
  assign wr_intr_enable = wr_en_i && (addr_i == `ADDR_INTR_ENABLE);
  assign wr_intr_test   = wr_en_i && (addr_i == `ADDR_INTR_TEST);
  assign wr_alert_cause = wr_en_i && (addr_i == `ADDR_ALERT_CAUSE);
  assign wr_alert_en    = wr_en_i && (addr_i == `ADDR_ALERT_EN);

  assign wr_ctrl   = (wr_en_i && addr_base == `ADDR_CLASS_CTRL) ? cls_sel : '0;
  assign wr_regwen = (wr_en_i && addr_base == `ADDR_CLR_REGWEN) ? cls_sel : '0;
  assign wr_clr    = (wr_en_i && addr_base == `ADDR_CLASS_CLR)  ? cls_sel : '0;

  // interrupt test and clear are single-cycle strobes to the irq block
  assign intr_test_o = wr_intr_test  ? wdata_i[`N_CLASSES-1:0] : '0;
  assign intr_clr_o  = wr_intr_state ? wdata_i[`N_CLASSES-1:0] : '0;

  ////////////////////////////////////////
  // register storage
  ////////////////////////////////////////

  alert_wrap_pkg::class_vec_t                intr_enable_q;
  alert_wrap_pkg::alert_vec_t                alert_cause_q;
  alert_wrap_pkg::alert_vec_t                alert_en_q;
  alert_wrap_pkg::reg_data_t [`N_CLASSES-1:0] ctrl_q;
  alert_wrap_pkg::class_vec_t                clr_regwen_q;
  alert_wrap_pkg::class_vec_t                class_clr_q;
  alert_wrap_pkg::alert_vec_t                cause_clr;
  alert_wrap_pkg::class_vec_t                regwen_clr;
  alert_wrap_pkg::class_vec_t                clr_req;

  assign cause_clr  = wr_alert_cause ? wdata_i[`N_ALERTS-1:0] : '0;
  // writing 0 drops the enable, writing 1 leaves it alone
  assign regwen_clr = wr_regwen & ~{`N_CLASSES{wdata_i[0]}};
  assign clr_req    = wr_clr & {`N_CLASSES{wdata_i[0]}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_enable_q <= '0;
      alert_en_q    <= '0;
      ctrl_q        <= '0;
    end else begin
      if (wr_intr_enable) begin
        intr_enable_q <= wdata_i[`N_CLASSES-1:0];
      end
      if (wr_alert_en) begin
        alert_en_q <= wdata_i[`N_ALERTS-1:0];
      end
      for (int c = 0; c < `N_CLASSES; c++) begin
        if (wr_ctrl[c]) begin
          ctrl_q[c] <= alert_wrap_pkg::reg_data_t'(wdata_i[ctrl_w-1:0]);
        end
      end
    end
  end

  // cause bits are sticky, a new event wins over a software clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_cause_q <= '0;
    end else begin
      alert_cause_q <= (alert_cause_q & ~cause_clr) | alert_trig_i;
    end
  end

  // clear enable only ever falls, by software or by autolock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_regwen_q <= '1;
      class_clr_q  <= '0;
    end else begin
      clr_regwen_q <= clr_regwen_q & ~(regwen_clr | autolock_clr_i);
      class_clr_q  <= clr_req & clr_regwen_q;
    end
  end

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  alert_wrap_pkg::reg_data_t rdata_d;
  alert_wrap_pkg::reg_data_t rdata_q;

  // test and clear words are write-only and read as 0
  always_comb begin
    rdata_d = '0;
    case (addr_i)
      `ADDR_INTR_STATE:  rdata_d[`N_CLASSES-1:0] = intr_state_i;
      `ADDR_INTR_ENABLE: rdata_d[`N_CLASSES-1:0] = intr_enable_q;
      `ADDR_ALERT_CAUSE: rdata_d[`N_ALERTS-1:0]  = alert_cause_q;
      `ADDR_ALERT_EN:    rdata_d[`N_ALERTS-1:0]  = alert_en_q;
      default: begin
        if (addr_base == `ADDR_CLASS_CTRL) begin
          rdata_d = ctrl_q[cls_idx];
        end else if (addr_base == `ADDR_CLR_REGWEN) begin
          rdata_d[0] = clr_regwen_q[cls_idx];
        end else if (addr_base == `ADDR_CLASS_STATUS) begin
          rdata_d[`ACCUM_CNT_W-1:0]             = accum_cnt_i[cls_idx];
          rdata_d[`ACCUM_CNT_W +: `ESC_STATE_W] = esc_state_i[cls_idx];
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o       = rdata_q;
  assign intr_enable_o = intr_enable_q;
  assign alert_cause_o = alert_cause_q;
  assign alert_en_o    = alert_en_q;
  assign class_ctrl_o  = ctrl_q;
  assign class_clr_o   = class_clr_q;

endmodule

/* alert_wrap_pkg.sv */
// alert handler register wrapper types
// vector typedefs for class, alert and register widths, plus the
// escalation state encoding reported by each class

`include "alert_wrap_defines.svh"

package alert_wrap_pkg;

  typedef logic [`N_CLASSES-1:0]             class_vec_t;
  typedef logic [`N_ALERTS-1:0]              alert_vec_t;
  // class c owns bits 4c+3:4c
  typedef logic [`N_CLASSES*`N_ESC_SEV-1:0]  esc_en_t;
  // two bits per escalation signal, eight bits per class
  typedef logic [`N_CLASSES*`N_ESC_SEV*2-1:0] esc_map_t;
  typedef logic [`ACCUM_CNT_W-1:0]           accum_cnt_t;
  typedef logic [`ADDR_W-1:0]                reg_addr_t;
  typedef logic [`DATA_W-1:0]                reg_data_t;

  // escalation FSM state as seen from the register side
  typedef enum logic [`ESC_STATE_W-1:0] {
    Idle     = 3'b000,
    Timeout  = 3'b001,
    Terminal = 3'b010,
    Phase0   = 3'b011,
    Phase1   = 3'b100,
    Phase2   = 3'b101,
    Phase3   = 3'b110,
    FsmError = 3'b111
  } esc_state_e;

endpackage

/* alert_wrap_defines.svh */
// alert handler register wrapper
// counts, widths, register word addresses and control word fields
`ifndef ALERT_WRAP_DEFINES_SVH
`define ALERT_WRAP_DEFINES_SVH

// sizes
`define N_CLASSES   4
`define N_ALERTS    8
`define N_ESC_SEV   4
`define ADDR_W      6
`define DATA_W      32
`define ACCUM_CNT_W 16
`define ESC_STATE_W 3

// register word addresses
// per-class registers take four consecutive words from their base
`define ADDR_INTR_STATE   0
`define ADDR_INTR_ENABLE  1
`define ADDR_INTR_TEST    2
`define ADDR_ALERT_CAUSE  3
`define ADDR_ALERT_EN     4
`define ADDR_CLASS_CTRL   8
`define ADDR_CLR_REGWEN   12
`define ADDR_CLASS_CLR    16
`define ADDR_CLASS_STATUS 20

// class control word fields
`define CTRL_EN_BIT   0
`define CTRL_LOCK_BIT 1
`define CTRL_EN_E_LSB 2
`define CTRL_MAP_LSB  6

`endif
